// File: src/fetch_pkg.sv
package fetch_pkg;

  // Address and instruction width
  localparam int xlen = 32;

  // Cache geometry, all sizes in bits
  localparam int blk_bits = 128;
  localparam int cache_bits = 512;
  localparam int num_set = cache_bits / blk_bits;
  localparam int idx_w = $clog2(num_set);
  localparam int off_w = $clog2(blk_bits / 8);
  localparam int tag_w = xlen - idx_w - off_w;

  // A line is split into 16-bit parcels, two per 32-bit word
  localparam int parcel_bits = 16;
  localparam int num_words = blk_bits / (2 * parcel_bits);

  // First fetch address after reset
  localparam logic [xlen-1:0] reset_pc = '0;

  typedef struct packed {
    logic [parcel_bits-1:0] parcel_hi;
    logic [parcel_bits-1:0] parcel_lo;
  } parcel_pair_t;

  // Fetched word, seen as one instruction or as two parcels
  typedef union packed {
    logic [xlen-1:0] whole;
    parcel_pair_t    parcels;
  } fetch_word_u;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
  } fetch_req_t;

  // Parcel at the request address is always in parcel_lo
  typedef struct packed {
    logic        valid;
    logic        miss;
    fetch_word_u word;
  } fetch_res_t;

  // Refill request, addr is line aligned
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                valid;
    logic [blk_bits-1:0] blk;
  } mem_res_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    fetch_word_u     instr;
    logic            compressed;
    logic            illegal;
  } instr_out_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
  } redirect_t;

endpackage

// File: src/fetch_pc_gen.sv
`timescale 1ns/1ns
module fetch_pc_gen (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  fetch_pkg::redirect_t  redirect_i,
  input  logic                  advance_i,
  input  logic                  advance_by_two_i,
  output fetch_pkg::fetch_req_t fetch_req_o
);

  logic [fetch_pkg::xlen-1:0] pc_q;
  logic [fetch_pkg::xlen-1:0] pc_step;
  logic [fetch_pkg::xlen-1:0] pc_next;
  logic                       run_q;

  // Compressed instructions move the PC by one parcel
  always_comb begin
    if (advance_by_two_i) begin
      pc_step = fetch_pkg::xlen'(2);
    end else begin
      pc_step = fetch_pkg::xlen'(4);
    end
    pc_next = pc_q + pc_step;
  end

  // Redirect wins over a normal advance
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= fetch_pkg::reset_pc;
    end else if (redirect_i.valid) begin
      pc_q <= redirect_i.pc;
    end else if (advance_i) begin
      pc_q <= pc_next;
    end
  end

  // Fetch starts in the first cycle after reset is released
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  always_comb begin
    fetch_req_o.valid = run_q;
    fetch_req_o.addr  = pc_q;
  end

endmodule

// File: src/align_buffer.sv
`timescale 1ns/1ns
module align_buffer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  fetch_pkg::fetch_req_t fetch_req_i,
  output fetch_pkg::fetch_res_t fetch_res_o,
  input  fetch_pkg::mem_res_t   mem_res_i,
  output fetch_pkg::mem_req_t   mem_req_o
);

  // Tag RAM, one valid bit and one tag per set
  logic [fetch_pkg::num_set-1:0] tag_vld_q;
  logic [fetch_pkg::tag_w-1:0]   tag_q [fetch_pkg::num_set];

  // Even parcels (halfword 0, 2, 4, 6) and odd parcels of every line
  logic [fetch_pkg::parcel_bits-1:0] even_bank_q [fetch_pkg::num_set][fetch_pkg::num_words];
  logic [fetch_pkg::parcel_bits-1:0] odd_bank_q  [fetch_pkg::num_set][fetch_pkg::num_words];

  // Address decode
  logic                              half_sel;
  logic [fetch_pkg::off_w-3:0]       word_sel;
  logic [fetch_pkg::off_w-3:0]       even_word;
  logic                              unalign;
  logic                              wrap;
  logic [fetch_pkg::idx_w-1:0]       odd_idx;
  logic [fetch_pkg::idx_w-1:0]       even_idx;
  logic [fetch_pkg::tag_w-1:0]       odd_tag;
  logic [fetch_pkg::tag_w-1:0]       even_tag;

  // Lookup and refill
  logic                              odd_hit;
  logic                              even_hit;
  logic                              fill_odd;
  logic                              fill_even;
  logic                              res_ok;
  logic                              need_refill;
  logic                              double_first;
  logic [fetch_pkg::parcel_bits-1:0] even_parcel;
  logic [fetch_pkg::parcel_bits-1:0] odd_parcel;
  logic [fetch_pkg::tag_w+fetch_pkg::idx_w-1:0] refill_line;
  logic [fetch_pkg::tag_w+fetch_pkg::idx_w-1:0] pend_line_q;
  logic [fetch_pkg::idx_w-1:0]       pend_idx;
  logic [fetch_pkg::tag_w-1:0]       pend_tag;

  // Sequencing state
  logic                              pending_q;
  logic                              waiting_second_q;
  logic                              ignore_valid_q;

  always_comb begin
    half_sel = fetch_req_i.addr[1];
    word_sel = fetch_req_i.addr[fetch_pkg::off_w-1:2];
    // Last halfword of a line, the upper parcel lives in the next line
    unalign  = &{word_sel, half_sel};

    odd_idx = fetch_req_i.addr[fetch_pkg::idx_w+fetch_pkg::off_w-1:fetch_pkg::off_w];
    odd_tag = fetch_req_i.addr[fetch_pkg::xlen-1:fetch_pkg::idx_w+fetch_pkg::off_w];
    {wrap, even_idx} = {1'b0, odd_idx} + (fetch_pkg::idx_w+1)'(unalign);
    // Set 3 to set 0 wrap moves into the next tag
    even_tag = odd_tag + fetch_pkg::tag_w'(wrap);

    // Even bank word, wraps to word 0 for an unaligned fetch
    even_word = word_sel + (fetch_pkg::off_w-2)'(half_sel);

    odd_hit  = tag_vld_q[odd_idx] && (tag_q[odd_idx] == odd_tag);
    even_hit = tag_vld_q[even_idx] && (tag_q[even_idx] == even_tag);
  end

  // Response arriving right after the first fill of a double miss is an echo
  assign res_ok = mem_res_i.valid && !ignore_valid_q;

  always_comb begin
    pend_idx  = pend_line_q[fetch_pkg::idx_w-1:0];
    pend_tag  = pend_line_q[fetch_pkg::tag_w+fetch_pkg::idx_w-1:fetch_pkg::idx_w];
    // A response only serves the lookup if it carries one of the two lines
    fill_odd  = res_ok && (pend_line_q == {odd_tag, odd_idx});
    fill_even = res_ok && (pend_line_q == {even_tag, even_idx});
    double_first = fill_odd && unalign && !even_hit && !fill_even;
  end

  // Bank reads with bypass of the line being refilled
  always_comb begin
    if (fill_even) begin
      even_parcel = mem_res_i.blk[even_word*2*fetch_pkg::parcel_bits +: fetch_pkg::parcel_bits];
    end else begin
      even_parcel = even_bank_q[even_idx][even_word];
    end
    if (fill_odd) begin
      odd_parcel = mem_res_i.blk[(2*word_sel+1)*fetch_pkg::parcel_bits +: fetch_pkg::parcel_bits];
    end else begin
      odd_parcel = odd_bank_q[odd_idx][word_sel];
    end
  end

  always_comb begin
    fetch_res_o.valid = fetch_req_i.valid && (odd_hit || fill_odd) && (even_hit || fill_even);
    fetch_res_o.miss  = need_refill;
    // Addressed parcel goes low
    if (half_sel) begin
      fetch_res_o.word.parcels.parcel_lo = odd_parcel;
      fetch_res_o.word.parcels.parcel_hi = even_parcel;
    end else begin
      fetch_res_o.word.parcels.parcel_lo = even_parcel;
      fetch_res_o.word.parcels.parcel_hi = odd_parcel;
    end
  end

  // One line per request, the addressed line before the next one
  always_comb begin
    need_refill = fetch_req_i.valid && !(odd_hit && even_hit);
    if (!odd_hit && !waiting_second_q) begin
      refill_line = {odd_tag, odd_idx};
    end else begin
      refill_line = {even_tag, even_idx};
    end
    mem_req_o.valid = need_refill && !pending_q;
    mem_req_o.addr  = {refill_line, {fetch_pkg::off_w{1'b0}}};
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q        <= 1'b0;
      waiting_second_q <= 1'b0;
      ignore_valid_q   <= 1'b0;
    end else begin
      if (mem_req_o.valid) begin
        pending_q <= 1'b1;
      end else if (res_ok) begin
        pending_q <= 1'b0;
      end
      ignore_valid_q <= res_ok && double_first;
      if (flush_i) begin
        waiting_second_q <= 1'b0;
      end else if (res_ok) begin
        waiting_second_q <= double_first;
      end
    end
  end

  // Line address of the outstanding refill
  always_ff @(posedge clk_i) begin
    if (mem_req_o.valid) begin
      pend_line_q <= refill_line;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tag_vld_q <= '0;
    end else if (flush_i) begin
      tag_vld_q <= '0;
    end else if (res_ok) begin
      tag_vld_q[pend_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_ok) begin
      tag_q[pend_idx] <= pend_tag;
      for (int w = 0; w < fetch_pkg::num_words; w++) begin
        even_bank_q[pend_idx][w] <=
          mem_res_i.blk[2*w*fetch_pkg::parcel_bits +: fetch_pkg::parcel_bits];
        odd_bank_q[pend_idx][w] <=
          mem_res_i.blk[(2*w+1)*fetch_pkg::parcel_bits +: fetch_pkg::parcel_bits];
      end
    end
  end

endmodule

// File: src/instr_predecode.sv
`timescale 1ns/1ns
module instr_predecode (
  input  fetch_pkg::fetch_res_t       fetch_res_i,
  input  logic [fetch_pkg::xlen-1:0]  pc_i,
  output fetch_pkg::instr_out_t       instr_o,
  output logic                        advance_by_two_o
);

  logic                              compressed;
  logic                              zero_parcel;
  logic [fetch_pkg::parcel_bits-1:0] parcel_lo;

  always_comb begin
    parcel_lo   = fetch_res_i.word.parcels.parcel_lo;
    // Low bits 2'b11 mark a 32-bit instruction, anything else is 16 bits
    compressed  = (parcel_lo[1:0] != 2'b11);
    // All-zero parcel is defined as illegal
    zero_parcel = (parcel_lo == '0);
  end

  always_comb begin
    instr_o.valid = fetch_res_i.valid;
    instr_o.pc    = pc_i;
    if (compressed) begin
      // Upper parcel belongs to the next instruction
      instr_o.instr.whole = {{fetch_pkg::parcel_bits{1'b0}}, parcel_lo};
    end else begin
      instr_o.instr.whole = fetch_res_i.word.whole;
    end
    instr_o.compressed = compressed;
    instr_o.illegal    = zero_parcel;
  end

  // Step size back to the PC stage
  assign advance_by_two_o = compressed;

endmodule

// File: src/fetch_frontend.sv
`timescale 1ns/1ns
module fetch_frontend (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  fetch_pkg::redirect_t  redirect_i,
  input  logic                  instr_ready_i,
  output fetch_pkg::instr_out_t instr_o,
  output fetch_pkg::mem_req_t   mem_req_o,
  input  fetch_pkg::mem_res_t   mem_res_i
);

  fetch_pkg::fetch_req_t fetch_req;
  fetch_pkg::fetch_res_t fetch_res;
  logic                  advance;
  logic                  advance_by_two;

  // PC moves only when an instruction is taken
  assign advance = instr_o.valid && instr_ready_i;

  fetch_pc_gen fetch_pc_gen_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .redirect_i       (redirect_i),
    .advance_i        (advance),
    .advance_by_two_i (advance_by_two),
    .fetch_req_o      (fetch_req)
  );

  align_buffer align_buffer_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .fetch_req_i (fetch_req),
    .fetch_res_o (fetch_res),
    .mem_res_i   (mem_res_i),
    .mem_req_o   (mem_req_o)
  );

  instr_predecode instr_predecode_inst (
    .fetch_res_i      (fetch_res),
    .pc_i             (fetch_req.addr),
    .instr_o          (instr_o),
    .advance_by_two_o (advance_by_two)
  );

endmodule

// File: verification/fetch_frontend_asserts.sv
`timescale 1ns/1ns
module fetch_frontend_asserts (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  fetch_pkg::redirect_t  redirect_i,
  input  logic                  instr_ready_i,
  input  fetch_pkg::instr_out_t instr_o,
  input  fetch_pkg::mem_req_t   mem_req_o
);

  // Number of failed assertions, read by the testbench at the end of the run
  int error_count = 0;

  // Refills always fetch whole lines
  req_line_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o.valid |-> (mem_req_o.addr[fetch_pkg::off_w-1:0] == '0))
  else begin
    $error("refill request address is not line aligned");
    error_count++;
  end

  // A stalled instruction repeats the same hit
  instr_stable_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (instr_o.valid && !instr_ready_i && !redirect_i.valid && !flush_i) |=> $stable(instr_o))
  else begin
    $error("instruction output changed while stalled");
    error_count++;
  end

  // Delivered instruction means both lines are present
  no_req_on_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_o.valid |-> !mem_req_o.valid)
  else begin
    $error("refill request issued while an instruction is delivered");
    error_count++;
  end

endmodule

bind fetch_frontend fetch_frontend_asserts fetch_frontend_asserts_inst (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .flush_i       (flush_i),
  .redirect_i    (redirect_i),
  .instr_ready_i (instr_ready_i),
  .instr_o       (instr_o),
  .mem_req_o     (mem_req_o)
);

// File: verification/fetch_frontend_tb.sv
`timescale 1ns/1ns
module fetch_frontend_tb;

  localparam int clk_period  = 20;
  localparam int wait_limit  = 64;
  localparam int num_steps   = 7;
  localparam int num_parcels = 512;

  typedef struct packed {
    logic        redir;
    logic [31:0] pc;
    logic        flush;
    logic [7:0]  count;
    logic [7:0]  stall;
    logic [7:0]  req_exp;
    logic        two_lines;
  } step_t;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  flush_i;
  fetch_pkg::redirect_t  redirect_i;
  logic                  instr_ready_i;
  fetch_pkg::instr_out_t instr_o;
  fetch_pkg::mem_req_t   mem_req_o;
  fetch_pkg::mem_res_t   mem_res_i;

  // Memory image of 64 lines with 8 parcels each
  logic [15:0]         mem_parcel [num_parcels];
  fetch_pkg::mem_req_t req_log [$];
  integer              seed;
  logic                mem_busy;
  int                  mem_wait;
  logic [31:0]         mem_addr;
  step_t               step_table [num_steps];
  logic [31:0]         exp_pc;

  fetch_frontend fetch_frontend_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .redirect_i    (redirect_i),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .mem_req_o     (mem_req_o),
    .mem_res_i     (mem_res_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  // A failed bound assertion ends the run at once
  always @(negedge clk_i) begin
    if (fetch_frontend_inst.fetch_frontend_asserts_inst.error_count != 0) begin
      report_failure("A bound protocol assertion failed");
    end
  end

  task automatic check_instr(input fetch_pkg::instr_out_t got, input fetch_pkg::instr_out_t want);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] t=%0t instr_o got=%h expected=%h", $time, got, want));
    end
  endtask

  task automatic check_req(input fetch_pkg::mem_req_t got, input fetch_pkg::mem_req_t want,
                           input string name);
    if (got !== want) begin
      report_failure($sformatf("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, want));
    end
  endtask

  task automatic check_count(input int got, input int want, input string name);
    if (got != want) begin
      report_failure($sformatf("[FAIL] t=%0t %s got=%0d expected=%0d", $time, name, got, want));
    end
  endtask

  function automatic logic [15:0] parcel_at(input logic [31:0] addr);
    return mem_parcel[addr[9:1]];
  endfunction

  // Reference walker where the high parcel only belongs to a 32-bit instruction
  function automatic fetch_pkg::instr_out_t expected_instr(input logic [31:0] pc);
    fetch_pkg::instr_out_t want;
    logic [15:0]           lo;
    lo = parcel_at(pc);
    want.valid = 1'b1;
    want.pc = pc;
    want.compressed = (lo[1:0] != 2'b11);
    want.illegal = (lo == 16'h0000);
    want.instr.parcels.parcel_lo = lo;
    if (want.compressed) begin
      want.instr.parcels.parcel_hi = 16'h0000;
    end else begin
      want.instr.parcels.parcel_hi = parcel_at(pc + 32'd2);
    end
    return want;
  endfunction

  function automatic logic [127:0] line_block(input logic [31:0] addr);
    logic [127:0] blk;
    int           base;
    base = int'(addr[9:4]) * 8;
    for (int i = 0; i < 8; i++) begin
      blk[16*i +: 16] = mem_parcel[base + i];
    end
    return blk;
  endfunction

  task automatic build_memory();
    for (int p = 0; p < num_parcels; p++) begin
      mem_parcel[p] = 16'($random(seed));
      if (p < 16) begin
        // First two lines hold aligned 32-bit instructions only
        if (p % 2 == 0) begin
          mem_parcel[p][1:0] = 2'b11;
        end
      end else if (p % 3 == 0) begin
        mem_parcel[p][1:0] = 2'b11;
      end else begin
        mem_parcel[p][1] = 1'b0;
      end
    end
    // Zero parcel at byte address 0xc8
    mem_parcel[100] = 16'h0000;
  endtask

  task automatic fill_step_table();
    // Columns are redirect, pc, flush, count, ready pattern, requests (ff unchecked), two lines
    step_table[0] = '{1'b0, 32'h0000_0000, 1'b0, 8'd8,  8'hFF,       8'd3,  1'b0};
    step_table[1] = '{1'b0, 32'h0000_0000, 1'b0, 8'd20, 8'hFF,       8'hFF, 1'b0};
    step_table[2] = '{1'b0, 32'h0000_0000, 1'b0, 8'd6,  8'b1000_0011, 8'hFF, 1'b0};
    // Straddle from set 3 into set 0 of the next tag
    step_table[3] = '{1'b1, 32'h0000_007E, 1'b0, 8'd3,  8'hFF,       8'd2,  1'b1};
    step_table[4] = '{1'b1, 32'h0000_007E, 1'b0, 8'd3,  8'hFF,       8'd0,  1'b0};
    step_table[5] = '{1'b1, 32'h0000_007E, 1'b1, 8'd3,  8'hFF,       8'd2,  1'b1};
    step_table[6] = '{1'b1, 32'h0000_00C8, 1'b0, 8'd4,  8'b1101_1011, 8'hFF, 1'b0};
  endtask

  // Memory serves one line at a time after 1 to 4 cycles
  initial begin
    mem_res_i = '0;
    mem_busy = 1'b0;
    mem_wait = 0;
    mem_addr = '0;
    forever begin
      @(negedge clk_i);
      mem_res_i.valid = 1'b0;
      if (mem_busy) begin
        mem_wait = mem_wait - 1;
        if (mem_wait == 0) begin
          mem_res_i.valid = 1'b1;
          mem_res_i.blk = line_block(mem_addr);
          mem_busy = 1'b0;
        end
      end else if (rst_n_i && mem_req_o.valid) begin
        mem_busy = 1'b1;
        mem_addr = mem_req_o.addr;
        mem_wait = 1 + ({$random(seed)} % 4);
        req_log.push_back(mem_req_o);
      end
    end
  end

  task automatic run_step(input step_t e);
    int                    accepted;
    int                    cyc;
    int                    idle;
    fetch_pkg::instr_out_t want;
    fetch_pkg::mem_req_t   want_req;
    accepted = 0;
    cyc = 0;
    idle = 0;
    @(negedge clk_i);
    if (e.redir || e.flush) begin
      instr_ready_i = 1'b0;
      redirect_i.valid = e.redir;
      redirect_i.pc = e.pc;
      flush_i = e.flush;
      if (e.redir) begin
        exp_pc = e.pc;
      end
      @(negedge clk_i);
      redirect_i = '0;
      flush_i = 1'b0;
    end
    while (accepted < int'(e.count)) begin
      instr_ready_i = e.stall[cyc % 8];
      cyc++;
      idle++;
      #(clk_period / 4);
      if (instr_o.valid) begin
        want = expected_instr(exp_pc);
        check_instr(instr_o, want);
        if (instr_ready_i) begin
          accepted++;
          idle = 0;
          exp_pc = exp_pc + (want.compressed ? 32'd2 : 32'd4);
        end
      end
      if (idle > wait_limit) begin
        report_failure("Timed out waiting for an instruction to be accepted");
      end
      @(negedge clk_i);
    end
    // Hold the next instruction until its lines are resident
    instr_ready_i = 1'b0;
    idle = 0;
    #(clk_period / 4);
    while (!instr_o.valid) begin
      @(negedge clk_i);
      #(clk_period / 4);
      idle++;
      if (idle > wait_limit) begin
        report_failure("Timed out waiting for the next instruction after a step");
      end
    end
    check_instr(instr_o, expected_instr(exp_pc));
    if (e.req_exp != 8'hFF) begin
      check_count(req_log.size(), int'(e.req_exp), "mem_req_o count");
    end
    if (e.two_lines) begin
      want_req.valid = 1'b1;
      want_req.addr = {e.pc[31:4], 4'h0};
      check_req(req_log[0], want_req, "mem_req_o first");
      want_req.addr = want_req.addr + 32'd16;
      check_req(req_log[1], want_req, "mem_req_o second");
    end
    req_log.delete();
  endtask

  initial begin
    int bound_errors;
    seed = 32'h1ef889f9;
    rst_n_i = 1'b0;
    flush_i = 1'b0;
    redirect_i = '0;
    instr_ready_i = 1'b0;
    exp_pc = fetch_pkg::reset_pc;
    build_memory();
    fill_step_table();
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int s = 0; s < num_steps; s++) begin
      run_step(step_table[s]);
    end
    repeat (4) @(negedge clk_i);
    bound_errors = fetch_frontend_inst.fetch_frontend_asserts_inst.error_count;
    if (bound_errors == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "%0d assertion errors", bound_errors);
    end
  end

endmodule

// File: build.f
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/align_buffer.sv
src/instr_predecode.sv
src/fetch_frontend.sv
verification/fetch_frontend_asserts.sv
verification/fetch_frontend_tb.sv
